// ==== verilog/alu_pkg.sv ====
package alu_pkg;

	// ======================================================================
	// widths and register map
	// ======================================================================
	localparam int DATA_W = 32;	// datapath width
	localparam int ADDR_W = 4;	// axi4-lite byte address width

	localparam logic [ADDR_W-1:0] REG_A    = 4'h0;	// operand a
	localparam logic [ADDR_W-1:0] REG_B    = 4'h4;	// operand b
	localparam logic [ADDR_W-1:0] REG_CTRL = 4'h8;	// opcode [4:0], cond select [11:8]
	localparam logic [ADDR_W-1:0] REG_RES  = 4'hC;	// alu result, read only

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// ======================================================================
	// opcodes
	// ======================================================================
	typedef enum logic [4:0] {
		OP_ADD    = 5'd0,
		OP_SUB    = 5'd1,
		OP_AND    = 5'd2,
		OP_OR     = 5'd3,
		OP_XOR    = 5'd4,
		OP_SLL    = 5'd5,
		OP_SRL    = 5'd6,
		OP_SRA    = 5'd7,
		OP_CMP    = 5'd8,	// integer compare
		OP_FCMP   = 5'd9,	// float compare
		OP_FCLASS = 5'd10,
		OP_FABS   = 5'd11,
		OP_FNABS  = 5'd12,
		OP_FNEG   = 5'd13,
		OP_FSIGN  = 5'd14,
		OP_CNTLZ  = 5'd15,
		OP_CNTPOP = 5'd16,
		OP_SEXTB  = 5'd17,
		OP_SEXTW  = 5'd18
	} alu_op_e;

	// condition vector bit positions
	localparam logic [3:0] CND_EQ   = 4'd0;
	localparam logic [3:0] CND_LT   = 4'd1;
	localparam logic [3:0] CND_LE   = 4'd2;
	localparam logic [3:0] CND_UN   = 4'd4;		// float only
	localparam logic [3:0] CND_NEUN = 4'd5;		// float only, shares slot with ltu
	localparam logic [3:0] CND_LTU  = 4'd5;		// integer only
	localparam logic [3:0] CND_LEU  = 4'd6;
	localparam logic [3:0] CND_NE   = 4'd8;
	localparam logic [3:0] CND_GE   = 4'd9;
	localparam logic [3:0] CND_GT   = 4'd10;
	localparam logic [3:0] CND_MGE  = 4'd11;	// magnitude >=
	localparam logic [3:0] CND_ORD  = 4'd12;
	localparam logic [3:0] CND_GEU  = 4'd13;
	localparam logic [3:0] CND_GTU  = 4'd14;
	localparam logic [3:0] CND_ALL  = 4'd15;	// whole vector

	// fclass bit positions
	localparam int CLS_NINF = 0;
	localparam int CLS_NEG  = 1;
	localparam int CLS_NSUB = 2;
	localparam int CLS_NZRO = 3;
	localparam int CLS_PZRO = 4;
	localparam int CLS_PSUB = 5;
	localparam int CLS_POS  = 6;
	localparam int CLS_PINF = 7;
	localparam int CLS_SNAN = 8;
	localparam int CLS_QNAN = 9;
	localparam int CLS_SIGN = 31;

	localparam logic [DATA_W-1:0] FP_POS_ONE = 32'h3F80_0000;	// +1.0
	localparam logic [DATA_W-1:0] FP_NEG_ONE = 32'hBF80_0000;	// -1.0

endpackage

// ==== verilog/fp_decomp.sv ====
`timescale 1ns/1ps

module fp_decomp
	import alu_pkg::*;
(
	input  logic [DATA_W-1:0] value_i,
	output logic              xz_o,		// exponent all zeros
	output logic              vz_o,		// value is zero, either sign
	output logic              inf_o,		// infinity
	output logic              xinf_o,	// exponent all ones
	output logic              snan_o,	// signalling nan
	output logic              qnan_o		// quiet nan
);

	logic [7:0]  exp_f;	// biased exponent
	logic [22:0] man_f;	// stored mantissa
	logic        mz;		// mantissa zero

	assign exp_f = value_i[30:23];
	assign man_f = value_i[22:0];
	assign mz    = ~|man_f;

	assign xz_o   = ~|exp_f;
	assign vz_o   = xz_o & mz;
	assign xinf_o = &exp_f;
	assign inf_o  = xinf_o & mz;
	// msb of the mantissa splits quiet from signalling
	assign qnan_o = xinf_o & man_f[22];
	assign snan_o = xinf_o & ~man_f[22] & ~mz;

endmodule

// ==== verilog/fp_compare.sv ====
`timescale 1ns/1ps

module fp_compare
	import alu_pkg::*;
(
	input  logic [DATA_W-1:0] a_i,
	input  logic [DATA_W-1:0] b_i,
	output logic [15:0]       cond_o
);

	logic a_vz, a_snan, a_qnan;
	logic b_vz, b_snan, b_qnan;
	logic unord;		// either side is a nan
	logic both_zero;	// +0 and -0 compare equal
	logic mag_lt, mag_eq;
	logic eq, lt, lt_raw;

	fp_decomp u_dec_a (.value_i(a_i), .xz_o(), .vz_o(a_vz), .inf_o(), .xinf_o(),
		.snan_o(a_snan), .qnan_o(a_qnan));
	fp_decomp u_dec_b (.value_i(b_i), .xz_o(), .vz_o(b_vz), .inf_o(), .xinf_o(),
		.snan_o(b_snan), .qnan_o(b_qnan));

	assign unord     = a_snan | a_qnan | b_snan | b_qnan;
	assign both_zero = a_vz & b_vz;
	assign mag_lt    = a_i[30:0] < b_i[30:0];	// sign-magnitude, so plain compare works
	assign mag_eq    = a_i[30:0] == b_i[30:0];

	always_comb
	begin
		if (a_i[31] != b_i[31])
			lt_raw = a_i[31] & ~both_zero;	// negative side is smaller
		else if (a_i[31])
			lt_raw = ~mag_lt & ~mag_eq;		// both negative, bigger magnitude is smaller
		else
			lt_raw = mag_lt;
	end

	assign eq = ~unord & (both_zero | (a_i == b_i));
	assign lt = ~unord & lt_raw;

	always_comb
	begin
		cond_o           = '0;
		cond_o[CND_EQ]   = eq;
		cond_o[CND_LT]   = lt;
		cond_o[CND_LE]   = lt | eq;
		cond_o[CND_UN]   = unord;
		cond_o[CND_NEUN] = ~eq;			// true on nan too
		cond_o[CND_GE]   = ~unord & ~lt;
		cond_o[CND_GT]   = ~unord & ~lt & ~eq;
		cond_o[CND_MGE]  = ~unord & ~mag_lt;
		cond_o[CND_ORD]  = ~unord;
	end

endmodule

// ==== verilog/bit_count.sv ====
`timescale 1ns/1ps

module bit_count
	import alu_pkg::*;
(
	input  logic [DATA_W-1:0] value_i,
	output logic [5:0]        lz_o,		// leading zeros, 32 for zero
	output logic [5:0]        pop_o		// number of set bits
);

	logic [1:0] sum2 [16];	// pairs
	logic [2:0] sum4 [8];	// nibbles
	logic [3:0] sum8 [4];	// bytes
	logic [4:0] sum16 [2];	// halfwords

	// scan from lsb up, the highest set bit wins
	always_comb
	begin
		lz_o = 6'd32;
		for (int i = 0; i < DATA_W; i++)
			if (value_i[i])
				lz_o = 6'(DATA_W - 1 - i);
	end

	// adder tree
	always_comb
	begin
		for (int i = 0; i < 16; i++)
			sum2[i] = {1'b0, value_i[2*i]} + {1'b0, value_i[2*i+1]};
		for (int i = 0; i < 8; i++)
			sum4[i] = {1'b0, sum2[2*i]} + {1'b0, sum2[2*i+1]};
		for (int i = 0; i < 4; i++)
			sum8[i] = {1'b0, sum4[2*i]} + {1'b0, sum4[2*i+1]};
		for (int i = 0; i < 2; i++)
			sum16[i] = {1'b0, sum8[2*i]} + {1'b0, sum8[2*i+1]};
		pop_o = {1'b0, sum16[0]} + {1'b0, sum16[1]};
	end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu
	import alu_pkg::*;
(
	input  logic [DATA_W-1:0] operand_a_i,
	input  logic [DATA_W-1:0] operand_b_i,
	input  alu_op_e           op_i,
	input  logic [3:0]        cond_sel_i,	// condition bit, or CND_ALL
	output logic [DATA_W-1:0] result_o
);

	logic [4:0]        shamt;		// shift amount from b
	logic              a_xz, a_vz, a_inf, a_xinf, a_snan, a_qnan;
	logic [15:0]       fcond;		// float condition vector
	logic [15:0]       icond;		// integer condition vector
	logic [15:0]       cond_vec;
	logic [DATA_W-1:0] cond_res;
	logic [DATA_W-1:0] fclass;
	logic [5:0]        lz, pop;

	assign shamt = operand_b_i[4:0];

	fp_decomp u_dec (.value_i(operand_a_i), .xz_o(a_xz), .vz_o(a_vz), .inf_o(a_inf),
		.xinf_o(a_xinf), .snan_o(a_snan), .qnan_o(a_qnan));

	fp_compare u_fcmp (.a_i(operand_a_i), .b_i(operand_b_i), .cond_o(fcond));

	bit_count u_cnt (.value_i(operand_a_i), .lz_o(lz), .pop_o(pop));

	// ======================================================================
	// integer compare
	// ======================================================================
	always_comb
	begin
		icond          = '0;
		icond[CND_EQ]  = operand_a_i == operand_b_i;
		icond[CND_LT]  = $signed(operand_a_i) < $signed(operand_b_i);
		icond[CND_LE]  = $signed(operand_a_i) <= $signed(operand_b_i);
		icond[CND_LTU] = operand_a_i < operand_b_i;
		icond[CND_LEU] = operand_a_i <= operand_b_i;
		icond[CND_NE]  = operand_a_i != operand_b_i;
		icond[CND_GE]  = $signed(operand_a_i) >= $signed(operand_b_i);
		icond[CND_GT]  = $signed(operand_a_i) > $signed(operand_b_i);
		icond[CND_GEU] = operand_a_i >= operand_b_i;
		icond[CND_GTU] = operand_a_i > operand_b_i;
	end

	assign cond_vec = (op_i == OP_FCMP) ? fcond : icond;
	// single bit lands in bit 0
	assign cond_res = (cond_sel_i == CND_ALL) ? {{(DATA_W-16){1'b0}}, cond_vec}
	                                          : {{(DATA_W-1){1'b0}}, cond_vec[cond_sel_i]};

	// ======================================================================
	// float classify
	// ======================================================================
	always_comb
	begin
		fclass           = '0;
		fclass[CLS_NINF] = operand_a_i[31] & a_inf;
		fclass[CLS_NEG]  = operand_a_i[31] & ~a_xz & ~a_xinf;	// normal numbers only
		fclass[CLS_NSUB] = operand_a_i[31] & a_xz & ~a_vz;
		fclass[CLS_NZRO] = operand_a_i[31] & a_vz;
		fclass[CLS_PZRO] = ~operand_a_i[31] & a_vz;
		fclass[CLS_PSUB] = ~operand_a_i[31] & a_xz & ~a_vz;
		fclass[CLS_POS]  = ~operand_a_i[31] & ~a_xz & ~a_xinf;
		fclass[CLS_PINF] = ~operand_a_i[31] & a_inf;
		fclass[CLS_SNAN] = a_snan;
		fclass[CLS_QNAN] = a_qnan;
		fclass[CLS_SIGN] = operand_a_i[31];	// sign copy at the top
	end

	// ======================================================================
	// result select
	// ======================================================================
	always_comb
	begin
		case (op_i)
		OP_ADD:    result_o = operand_a_i + operand_b_i;
		OP_SUB:    result_o = operand_a_i - operand_b_i;
		OP_AND:    result_o = operand_a_i & operand_b_i;
		OP_OR:     result_o = operand_a_i | operand_b_i;
		OP_XOR:    result_o = operand_a_i ^ operand_b_i;
		OP_SLL:    result_o = operand_a_i << shamt;
		OP_SRL:    result_o = operand_a_i >> shamt;
		OP_SRA:    result_o = DATA_W'($signed(operand_a_i) >>> shamt);	// sign fill
		OP_CMP:    result_o = cond_res;
		OP_FCMP:   result_o = cond_res;
		OP_FCLASS: result_o = fclass;
		OP_FABS:   result_o = {1'b0, operand_a_i[30:0]};
		OP_FNABS:  result_o = {1'b1, operand_a_i[30:0]};
		OP_FNEG:   result_o = {~operand_a_i[31], operand_a_i[30:0]};
		OP_FSIGN:  result_o = a_vz ? '0 : (operand_a_i[31] ? FP_NEG_ONE : FP_POS_ONE);
		OP_CNTLZ:  result_o = {{(DATA_W-6){1'b0}}, lz};
		OP_CNTPOP: result_o = {{(DATA_W-6){1'b0}}, pop};
		OP_SEXTB:  result_o = {{(DATA_W-8){operand_a_i[7]}}, operand_a_i[7:0]};
		OP_SEXTW:  result_o = {{(DATA_W-16){operand_a_i[15]}}, operand_a_i[15:0]};
		default:   result_o = '0;	// undefined codes
		endcase
	end

endmodule

// ==== verilog/alu_axil_regs.sv ====
`timescale 1ns/1ps

module alu_axil_regs
	import alu_pkg::*;
(
	input  logic                clk_i,
	input  logic                arst_n_i,
	// write address / data / response
	input  logic [ADDR_W-1:0]   s_awaddr_i,
	input  logic                s_awvalid_i,
	output logic                s_awready_o,
	input  logic [DATA_W-1:0]   s_wdata_i,
	input  logic [DATA_W/8-1:0] s_wstrb_i,
	input  logic                s_wvalid_i,
	output logic                s_wready_o,
	output logic [1:0]          s_bresp_o,
	output logic                s_bvalid_o,
	input  logic                s_bready_i,
	// read address / data
	input  logic [ADDR_W-1:0]   s_araddr_i,
	input  logic                s_arvalid_i,
	output logic                s_arready_o,
	output logic [DATA_W-1:0]   s_rdata_o,
	output logic [1:0]          s_rresp_o,
	output logic                s_rvalid_o,
	input  logic                s_rready_i,
	// alu side
	output logic [DATA_W-1:0]   operand_a_o,
	output logic [DATA_W-1:0]   operand_b_o,
	output alu_op_e             op_o,
	output logic [3:0]          cond_sel_o,
	input  logic [DATA_W-1:0]   result_i
);

	logic [DATA_W-1:0] reg_a_q, reg_b_q, reg_ctrl_q;
	logic              wr_hs;			// aw and w accepted together
	logic              rd_hs;			// ar accepted
	logic              wr_ok;			// write target is a writable register
	logic [DATA_W-1:0] rd_data_d;
	logic [1:0]        rd_resp_d;

	// ======================================================================
	// write channel
	// ======================================================================
	assign wr_hs       = s_awvalid_i & s_wvalid_i & ~s_bvalid_o;	// wait out pending response
	assign s_awready_o = wr_hs;
	assign s_wready_o  = wr_hs;
	assign wr_ok       = (s_awaddr_i == REG_A) || (s_awaddr_i == REG_B) ||
	                     (s_awaddr_i == REG_CTRL);

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			reg_a_q    <= '0;
			reg_b_q    <= '0;
			reg_ctrl_q <= '0;
		end
		else if (wr_hs)
		begin
			for (int i = 0; i < DATA_W/8; i++)
			begin
				if (s_wstrb_i[i])
				begin
					case (s_awaddr_i)
					REG_A:    reg_a_q[i*8 +: 8]    <= s_wdata_i[i*8 +: 8];
					REG_B:    reg_b_q[i*8 +: 8]    <= s_wdata_i[i*8 +: 8];
					REG_CTRL: reg_ctrl_q[i*8 +: 8] <= s_wdata_i[i*8 +: 8];
					default:  ;	// result and holes are not writable
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			s_bvalid_o <= 1'b0;
		else if (wr_hs)
			s_bvalid_o <= 1'b1;
		else if (s_bready_i)
			s_bvalid_o <= 1'b0;	// held until the master takes it
	end

	always_ff @(posedge clk_i)
		if (wr_hs)
			s_bresp_o <= wr_ok ? RESP_OKAY : RESP_SLVERR;

	// ======================================================================
	// read channel
	// ======================================================================
	assign rd_hs       = s_arvalid_i & ~s_rvalid_o;
	assign s_arready_o = rd_hs;

	always_comb
	begin
		rd_resp_d = RESP_OKAY;
		case (s_araddr_i)
		REG_A:    rd_data_d = reg_a_q;
		REG_B:    rd_data_d = reg_b_q;
		REG_CTRL: rd_data_d = reg_ctrl_q;
		REG_RES:  rd_data_d = result_i;		// live alu output at ar handshake
		default:
		begin
			rd_data_d = '0;
			rd_resp_d = RESP_SLVERR;
		end
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			s_rvalid_o <= 1'b0;
		else if (rd_hs)
			s_rvalid_o <= 1'b1;
		else if (s_rready_i)
			s_rvalid_o <= 1'b0;
	end

	// data only moves on a new handshake, so it stays put under back-pressure
	always_ff @(posedge clk_i)
	begin
		if (rd_hs)
		begin
			s_rdata_o <= rd_data_d;
			s_rresp_o <= rd_resp_d;
		end
	end

	assign operand_a_o = reg_a_q;
	assign operand_b_o = reg_b_q;
	assign op_o        = alu_op_e'(reg_ctrl_q[4:0]);
	assign cond_sel_o  = reg_ctrl_q[11:8];

endmodule

// ==== verilog/alu_top.sv ====
`timescale 1ns/1ps

module alu_top
	import alu_pkg::*;
(
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  logic [ADDR_W-1:0]   s_awaddr_i,
	input  logic                s_awvalid_i,
	output logic                s_awready_o,
	input  logic [DATA_W-1:0]   s_wdata_i,
	input  logic [DATA_W/8-1:0] s_wstrb_i,
	input  logic                s_wvalid_i,
	output logic                s_wready_o,
	output logic [1:0]          s_bresp_o,
	output logic                s_bvalid_o,
	input  logic                s_bready_i,
	input  logic [ADDR_W-1:0]   s_araddr_i,
	input  logic                s_arvalid_i,
	output logic                s_arready_o,
	output logic [DATA_W-1:0]   s_rdata_o,
	output logic [1:0]          s_rresp_o,
	output logic                s_rvalid_o,
	input  logic                s_rready_i
);

	logic [DATA_W-1:0] operand_a, operand_b, result;
	alu_op_e           op;
	logic [3:0]        cond_sel;

	// register port
	alu_axil_regs u_regs (.clk_i(clk_i), .arst_n_i(arst_n_i),
		.s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
		.s_wdata_i(s_wdata_i), .s_wstrb_i(s_wstrb_i), .s_wvalid_i(s_wvalid_i),
		.s_wready_o(s_wready_o), .s_bresp_o(s_bresp_o), .s_bvalid_o(s_bvalid_o),
		.s_bready_i(s_bready_i), .s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i),
		.s_arready_o(s_arready_o), .s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o),
		.s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i),
		.operand_a_o(operand_a), .operand_b_o(operand_b), .op_o(op),
		.cond_sel_o(cond_sel), .result_i(result));

	// combinational datapath
	alu u_alu (.operand_a_i(operand_a), .operand_b_i(operand_b), .op_i(op),
		.cond_sel_i(cond_sel), .result_o(result));

endmodule

// ==== tests/alu_asserts.sv ====
`timescale 1ns/1ps

module alu_asserts
	import alu_pkg::*;
(
	input logic              clk_i,
	input logic              arst_n_i,
	input logic              awvalid_i,
	input logic              wvalid_i,
	input logic              awready_i,
	input logic              bvalid_i,
	input logic              bready_i,
	input logic              rvalid_i,
	input logic              rready_i,
	input logic [DATA_W-1:0] rdata_i
);

	// ======================================================================
	// response channels hold until taken
	// ======================================================================
	bvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		bvalid_i && !bready_i |=> bvalid_i)
		else $error("bvalid dropped before bready");

	rvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		rvalid_i && !rready_i |=> rvalid_i)
		else $error("rvalid dropped before rready");

	rdata_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		rvalid_i && !rready_i |=> $stable(rdata_i))
		else $error("rdata moved under back-pressure");

	// address and data are only taken together
	aw_w_joint: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		awready_i |-> awvalid_i && wvalid_i)
		else $error("awready without both awvalid and wvalid");

	reset_quiet: assert property (@(posedge clk_i)
		!arst_n_i |-> !bvalid_i && !rvalid_i)
		else $error("valid output high during reset");

endmodule

bind alu_axil_regs alu_asserts u_asserts (.clk_i(clk_i), .arst_n_i(arst_n_i),
	.awvalid_i(s_awvalid_i), .wvalid_i(s_wvalid_i), .awready_i(s_awready_o),
	.bvalid_i(s_bvalid_o), .bready_i(s_bready_i), .rvalid_i(s_rvalid_o),
	.rready_i(s_rready_i), .rdata_i(s_rdata_o));

// ==== tests/alu_tb.sv ====
`timescale 1ns/1ps

module alu_tb
	import alu_pkg::*;
();

	// ======================================================================
	// clock, stimulus timing and run limit
	// ======================================================================
	localparam int          CLK_PERIOD = 100;	// ns
	localparam int          DRIVE_DLY  = 5;	// inputs move this long after the rising edge
	localparam logic [31:0] SEED       = 32'h0c0d083e;
	// close to 480 alu checks at four transfers of two cycles each, about 4000 cycles
	localparam int          CYCLE_LIMIT = 20000;

	// test vectors for the float ops, both signs of each class
	localparam logic [DATA_W-1:0] FP_VALS [12] = '{
		32'h0000_0000, 32'h8000_0000,	// zeros
		32'h0000_0001, 32'h807F_FFFF,	// subnormals
		32'h3F80_0000, 32'hC049_0FDB,	// normals
		32'h7F80_0000, 32'hFF80_0000,	// infinities
		32'h7FC0_0000, 32'hFFC0_0001,	// quiet nans
		32'h7F80_0001, 32'hFFA0_0000	// signalling nans
	};

	logic                clk;
	logic                arst_n;
	logic [ADDR_W-1:0]   s_awaddr;
	logic                s_awvalid;
	logic                s_awready;
	logic [DATA_W-1:0]   s_wdata;
	logic [DATA_W/8-1:0] s_wstrb;
	logic                s_wvalid;
	logic                s_wready;
	logic [1:0]          s_bresp;
	logic                s_bvalid;
	logic                s_bready;
	logic [ADDR_W-1:0]   s_araddr;
	logic                s_arvalid;
	logic                s_arready;
	logic [DATA_W-1:0]   s_rdata;
	logic [1:0]          s_rresp;
	logic                s_rvalid;
	logic                s_rready;
	int                  cycle_cnt = 0;

	alu_top UUT (.clk_i(clk), .arst_n_i(arst_n),
		.s_awaddr_i(s_awaddr), .s_awvalid_i(s_awvalid), .s_awready_o(s_awready),
		.s_wdata_i(s_wdata), .s_wstrb_i(s_wstrb), .s_wvalid_i(s_wvalid),
		.s_wready_o(s_wready), .s_bresp_o(s_bresp), .s_bvalid_o(s_bvalid),
		.s_bready_i(s_bready), .s_araddr_i(s_araddr), .s_arvalid_i(s_arvalid),
		.s_arready_o(s_arready), .s_rdata_o(s_rdata), .s_rresp_o(s_rresp),
		.s_rvalid_o(s_rvalid), .s_rready_i(s_rready));

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// watchdog
	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT)
			abort_run($sformatf("timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
	end

	// ======================================================================
	// failure reporting and compare tasks
	// ======================================================================
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
		input string what);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s, got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s, resp %b expected %b", $time, what, got, exp));
	endtask

	// ======================================================================
	// axi4-lite master, called and returning at a drive point
	// ======================================================================
	task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [DATA_W/8-1:0] strb, input int stall, output logic [1:0] resp);
		s_awaddr  = addr;
		s_wdata   = data;
		s_wstrb   = strb;
		s_awvalid = 1'b1;
		s_wvalid  = 1'b1;
		@(negedge clk);		// ready is combinational, look at mid cycle
		while (!s_awready)
			@(negedge clk);
		if (!s_wready)
			abort_run("wready did not rise together with awready");
		@(posedge clk);		// aw and w taken here
		#DRIVE_DLY;
		s_awvalid = 1'b0;
		s_wvalid  = 1'b0;
		if (!s_bvalid)
			abort_run("write response did not arrive one cycle after the handshake");
		resp = s_bresp;
		repeat (stall)
		begin
			@(posedge clk);
			#DRIVE_DLY;
			if (!s_bvalid || s_bresp !== resp)
				abort_run("write response dropped or changed while bready was low");
		end
		s_bready = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		s_bready = 1'b0;
		if (s_bvalid)
			abort_run("bvalid stayed high after bready");
	endtask

	task automatic axil_read(input logic [ADDR_W-1:0] addr, input int stall,
		output logic [DATA_W-1:0] data, output logic [1:0] resp);
		s_araddr  = addr;
		s_arvalid = 1'b1;
		@(negedge clk);
		while (!s_arready)
			@(negedge clk);
		@(posedge clk);		// ar taken here
		#DRIVE_DLY;
		s_arvalid = 1'b0;
		if (!s_rvalid)
			abort_run("read data did not arrive one cycle after the address handshake");
		data = s_rdata;
		resp = s_rresp;
		repeat (stall)
		begin
			@(posedge clk);
			#DRIVE_DLY;
			if (!s_rvalid || s_rdata !== data || s_rresp !== resp)
				abort_run("read data dropped or changed while rready was low");
		end
		s_rready = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		s_rready = 1'b0;
		if (s_rvalid)
			abort_run("rvalid stayed high after rready");
	endtask

	task automatic read_and_compare(input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] exp, input string what);
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		axil_read(addr, 0, data, resp);
		check_resp(resp, RESP_OKAY, what);
		check_data(data, exp, what);
	endtask

	// ======================================================================
	// reference model
	// ======================================================================
	function automatic logic fp_is_nan(input logic [DATA_W-1:0] x);
		return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
	endfunction

	function automatic logic [15:0] int_cond(input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b);
		logic [15:0] v;
		v          = '0;
		v[CND_EQ]  = a == b;
		v[CND_NE]  = a != b;
		v[CND_LT]  = $signed(a) < $signed(b);
		v[CND_LE]  = $signed(a) <= $signed(b);
		v[CND_GE]  = $signed(a) >= $signed(b);
		v[CND_GT]  = $signed(a) > $signed(b);
		v[CND_LTU] = a < b;
		v[CND_LEU] = a <= b;
		v[CND_GEU] = a >= b;
		v[CND_GTU] = a > b;
		return v;
	endfunction

	// floats mapped onto signed keys, so -0 and +0 land on the same key
	function automatic logic [15:0] float_cond(input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b);
		logic [15:0]        v;
		logic signed [32:0] ka, kb;
		logic               un;
		un = fp_is_nan(a) || fp_is_nan(b);
		ka = a[31] ? -$signed({2'b00, a[30:0]}) : $signed({2'b00, a[30:0]});
		kb = b[31] ? -$signed({2'b00, b[30:0]}) : $signed({2'b00, b[30:0]});
		v           = '0;
		v[CND_EQ]   = !un && ka == kb;
		v[CND_LT]   = !un && ka < kb;
		v[CND_LE]   = !un && ka <= kb;
		v[CND_UN]   = un;
		v[CND_NEUN] = un || ka != kb;
		v[CND_GE]   = !un && ka >= kb;
		v[CND_GT]   = !un && ka > kb;
		v[CND_MGE]  = !un && a[30:0] >= b[30:0];	// magnitudes only
		v[CND_ORD]  = !un;
		return v;
	endfunction

	function automatic logic [DATA_W-1:0] fp_class(input logic [DATA_W-1:0] x);
		logic [DATA_W-1:0] c;
		logic              s, zero, sub, inf, nan, norm;
		s    = x[31];
		zero = x[30:0] == 31'd0;
		sub  = x[30:23] == 8'd0 && !zero;
		inf  = x[30:0] == 31'h7F80_0000;
		nan  = fp_is_nan(x);
		norm = x[30:23] != 8'd0 && x[30:23] != 8'hFF;	// neither zero/sub nor inf/nan
		c           = '0;
		c[CLS_NINF] = s && inf;
		c[CLS_NEG]  = s && norm;
		c[CLS_NSUB] = s && sub;
		c[CLS_NZRO] = s && zero;
		c[CLS_PZRO] = !s && zero;
		c[CLS_PSUB] = !s && sub;
		c[CLS_POS]  = !s && norm;
		c[CLS_PINF] = !s && inf;
		c[CLS_SNAN] = nan && !x[22];	// quiet bit clear
		c[CLS_QNAN] = nan && x[22];
		c[CLS_SIGN] = s;
		return c;
	endfunction

	function automatic logic [DATA_W-1:0] ref_model(input alu_op_e op, input logic [3:0] sel,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		logic [15:0]       vec;
		logic [DATA_W-1:0] res;
		int                lz;
		vec = (op == OP_FCMP) ? float_cond(a, b) : int_cond(a, b);
		lz  = 0;
		while (lz < 32 && !a[31-lz])
			lz++;
		case (op)
		OP_ADD:    res = a + b;
		OP_SUB:    res = a - b;
		OP_AND:    res = a & b;
		OP_OR:     res = a | b;
		OP_XOR:    res = a ^ b;
		OP_SLL:    res = a << b[4:0];
		OP_SRL:    res = a >> b[4:0];
		OP_SRA:    res = $signed(a) >>> b[4:0];
		OP_CMP, OP_FCMP:
			res = (sel == CND_ALL) ? {16'd0, vec} : {31'd0, vec[sel]};
		OP_FCLASS: res = fp_class(a);
		OP_FABS:   res = a & 32'h7FFF_FFFF;
		OP_FNABS:  res = a | 32'h8000_0000;
		OP_FNEG:   res = a ^ 32'h8000_0000;
		OP_FSIGN:  res = (a[30:0] == 31'd0) ? 32'h0 : (a[31] ? 32'hBF80_0000 : 32'h3F80_0000);
		OP_CNTLZ:  res = 32'(lz);
		OP_CNTPOP: res = 32'($countones(a));
		OP_SEXTB:  res = 32'($signed(a[7:0]));
		OP_SEXTW:  res = 32'($signed(a[15:0]));
		default:   res = '0;
		endcase
		return res;
	endfunction

	// load a, b and control, then read the result back
	task automatic run_check(input alu_op_e op, input logic [3:0] sel,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		logic [1:0] resp;
		axil_write(REG_A, a, 4'hF, 0, resp);
		check_resp(resp, RESP_OKAY, "write A");
		axil_write(REG_B, b, 4'hF, 0, resp);
		check_resp(resp, RESP_OKAY, "write B");
		axil_write(REG_CTRL, {20'd0, sel, 3'd0, op}, 4'hF, 0, resp);
		check_resp(resp, RESP_OKAY, "write control");
		read_and_compare(REG_RES, ref_model(op, sel, a, b),
			$sformatf("%s sel=%0d a=%h b=%h", op.name(), sel, a, b));
	endtask

	// ======================================================================
	// directed tests
	// ======================================================================
	task automatic test_reset_values;
		if (s_bvalid || s_rvalid || s_awready || s_wready || s_arready)
			abort_run("a handshake output was high right after reset");
		read_and_compare(REG_A, '0, "A after reset");
		read_and_compare(REG_B, '0, "B after reset");
		read_and_compare(REG_CTRL, '0, "control after reset");
		read_and_compare(REG_RES, '0, "result after reset");	// add of zeros
	endtask

	task automatic test_int_ops;
		alu_op_e ops [8];
		ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA};
		for (int i = 0; i < 8; i++)
			for (int n = 0; n < 6; n++)
				run_check(ops[i], CND_ALL, $urandom(), $urandom());
		// shift by 0 and 31, upper bits of b must not matter
		for (int i = 5; i < 8; i++)
		begin
			run_check(ops[i], CND_ALL, 32'h8000_0F01, 32'hFFFF_FFE0);
			run_check(ops[i], CND_ALL, 32'h8000_0F01, 32'h0000_001F);
		end
	endtask

	task automatic test_int_compare;
		logic [DATA_W-1:0] pa [6];
		logic [DATA_W-1:0] pb [6];
		pa = '{32'h1234_5678, 32'h7FFF_FFFF, 32'h8000_0000, 32'h0, 32'hFFFF_FFFF, 32'h8000_0000};
		pb = '{32'h1234_5678, 32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'h0, 32'h8000_0000};
		for (int s = 0; s < 16; s++)
		begin
			for (int i = 0; i < 6; i++)
				run_check(OP_CMP, 4'(s), pa[i], pb[i]);	// equal and boundary pairs
			for (int n = 0; n < 4; n++)
				run_check(OP_CMP, 4'(s), $urandom(), $urandom());
		end
	endtask

	task automatic test_float_ops;
		alu_op_e fops [5];
		fops = '{OP_FCLASS, OP_FABS, OP_FNABS, OP_FNEG, OP_FSIGN};
		for (int i = 0; i < 12; i++)
			for (int k = 0; k < 5; k++)
				run_check(fops[k], CND_ALL, FP_VALS[i], 32'h0);
		for (int i = 0; i < 12; i++)
			for (int j = 0; j < 12; j++)
				run_check(OP_FCMP, CND_ALL, FP_VALS[i], FP_VALS[j]);
		for (int s = 0; s < 15; s++)
		begin
			run_check(OP_FCMP, 4'(s), 32'h8000_0000, 32'h0000_0000);	// -0 vs +0
			run_check(OP_FCMP, 4'(s), 32'h3F80_0000, 32'h7FC0_0000);	// against nan
			run_check(OP_FCMP, 4'(s), 32'hC000_0000, 32'h3F80_0000);
		end
	endtask

	task automatic test_count_sext;
		logic [DATA_W-1:0] words [6];
		words = '{32'h0, 32'hFFFF_FFFF, 32'h0000_0001, 32'h8000_0000, 32'h0, 32'h0};
		words[4] = $urandom();
		words[5] = $urandom() >> 13;	// some leading zeros
		for (int i = 0; i < 6; i++)
		begin
			run_check(OP_CNTLZ, CND_ALL, words[i], 32'h0);
			run_check(OP_CNTPOP, CND_ALL, words[i], 32'h0);
		end
		run_check(OP_SEXTB, CND_ALL, 32'h1234_5680, 32'h0);	// bit 7 set
		run_check(OP_SEXTB, CND_ALL, 32'hFFFF_FF7F, 32'h0);
		run_check(OP_SEXTW, CND_ALL, 32'h0000_8001, 32'h0);	// bit 15 set
		run_check(OP_SEXTW, CND_ALL, 32'hFFFF_7FFF, 32'h0);
		run_check(alu_op_e'(5'd25), CND_ALL, 32'h1234_5678, 32'h1);	// undefined code
	endtask

	task automatic test_reg_port;
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		axil_write(REG_A, 32'h1122_3344, 4'hF, 0, resp);
		check_resp(resp, RESP_OKAY, "full write A");
		axil_write(REG_A, 32'hAABB_CCDD, 4'b0101, 0, resp);
		check_resp(resp, RESP_OKAY, "partial write A");
		read_and_compare(REG_A, 32'h11BB_33DD, "A after partial strobe");
		axil_write(REG_B, 32'h5566_7788, 4'hF, 0, resp);
		axil_write(REG_CTRL, 32'h0000_0F08, 4'hF, 0, resp);
		// writes that must be refused
		axil_write(REG_RES, 32'hFFFF_FFFF, 4'hF, 0, resp);
		check_resp(resp, RESP_SLVERR, "write to result");
		axil_write(4'h2, 32'hFFFF_FFFF, 4'hF, 0, resp);
		check_resp(resp, RESP_SLVERR, "write to unmapped offset");
		axil_read(4'h6, 0, data, resp);
		check_resp(resp, RESP_SLVERR, "read of unmapped offset");
		read_and_compare(REG_A, 32'h11BB_33DD, "A after refused writes");
		read_and_compare(REG_B, 32'h5566_7788, "B after refused writes");
		read_and_compare(REG_CTRL, 32'h0000_0F08, "control after refused writes");
		// back-pressure on both response channels
		axil_write(REG_B, 32'h0BAD_F00D, 4'hF, 5, resp);
		check_resp(resp, RESP_OKAY, "write B under bready stall");
		axil_read(REG_B, 5, data, resp);
		check_resp(resp, RESP_OKAY, "read B under rready stall");
		check_data(data, 32'h0BAD_F00D, "B under rready stall");
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================
	initial
	begin
		void'($urandom(SEED));
		arst_n    = 1'b0;
		s_awaddr  = '0;
		s_awvalid = 1'b0;
		s_wdata   = '0;
		s_wstrb   = '0;
		s_wvalid  = 1'b0;
		s_bready  = 1'b0;
		s_araddr  = '0;
		s_arvalid = 1'b0;
		s_rready  = 1'b0;
		repeat (3) @(posedge clk);
		#DRIVE_DLY;
		arst_n = 1'b1;
		test_reset_values();
		test_int_ops();
		test_int_compare();
		test_float_ops();
		test_count_sext();
		test_reg_port();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/alu_pkg.sv
verilog/fp_decomp.sv
verilog/fp_compare.sv
verilog/bit_count.sv
verilog/alu.sv
verilog/alu_axil_regs.sv
verilog/alu_top.sv
tests/alu_asserts.sv
tests/alu_tb.sv

// ==== Makefile ====
# Verilator build and run of the alu testbench

VERILATOR  ?= verilator
TOP        ?= alu_tb
SEED_FLAGS ?= +verilator+seed+1
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --assert --timing
FILELIST   := verilog.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_FLAGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
